//--- logic/esc_pkg.sv
// escalation class package
// widths, FSM state encoding and the config / status words shared by
// the alert intake, the accumulator and the escalation timer

package esc_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // number of escalation outputs
  parameter int unsigned N_ESC_SEV = 4;
  // number of timed escalation phases
  parameter int unsigned N_PHASES  = 4;
  // width of a phase index
  parameter int unsigned PHASE_DW  = 2;
  // accumulation, timeout and phase counter width
  parameter int unsigned CNT_W     = 16;

  //////////////////////////////
  // FSM states
  //////////////////////////////

  // phase states carry the phase index in the low bits, msb set
  typedef enum logic [2:0] {
    Idle     = 3'b000,
    Timeout  = 3'b001,
    Terminal = 3'b011,
    Phase0   = 3'b100,
    Phase1   = 3'b101,
    Phase2   = 3'b110,
    Phase3   = 3'b111
  } esc_state_e;

  // static class configuration, 111 bits
  typedef struct packed {
    logic                               en;
    logic [CNT_W-1:0]                   accu_thresh;
    logic [CNT_W-1:0]                   timeout_cyc;
    logic [N_PHASES-1:0][CNT_W-1:0]     phase_cyc;
    logic [N_ESC_SEV-1:0]               esc_en;
    logic [N_ESC_SEV-1:0][PHASE_DW-1:0] esc_map;
    logic [PHASE_DW-1:0]                crashdump_phase;
  } esc_cfg_t;

  // observable class status
  typedef struct packed {
    esc_state_e       state;
    logic [CNT_W-1:0] esc_cnt;
    logic             esc_trig;
    logic             crashdump_valid;
  } esc_status_t;

endpackage

//--- logic/alert_intake.sv
// alert intake
// masks incoming alert pulses, folds them into a single event per cycle,
// registers that event as the accept strobe and keeps the irq pending flag

module alert_intake #(
  parameter int unsigned N_ALERTS = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [N_ALERTS-1:0] alert_i,
  input  logic [N_ALERTS-1:0] alert_en_i,
  input  logic                clr_i,
  output logic                accept_o,
  output logic                irq_o
);

  // at least one enabled alert in this cycle
  logic alert_evt;
  logic accept_q;
  logic irq_q;

  //////////////////////////////
  // masking
  //////////////////////////////

  // several enabled alerts in one cycle still count once
  assign alert_evt = |(alert_i & alert_en_i);

  //////////////////////////////
  // strobe and pending flag
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      // clr beats a simultaneous alert on both the strobe and the flag
      accept_q <= alert_evt & ~clr_i;
      if (clr_i) begin
        irq_q <= 1'b0;
      end else if (alert_evt) begin
        irq_q <= 1'b1;
      end
    end
  end

  // one cycle pulse to the accumulator, no back-pressure
  assign accept_o = accept_q;
  // level, also the timeout enable of the timer
  assign irq_o    = irq_q;

endmodule

//--- logic/alert_accu.sv
// alert accumulator
// saturating count of accepted alerts; raises a one cycle trigger in the
// strobe cycle whose post-increment count reaches the threshold

module alert_accu (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      accept_i,
  input  logic                      clr_i,
  input  logic [esc_pkg::CNT_W-1:0] thresh_i,
  output logic [esc_pkg::CNT_W-1:0] cnt_o,
  output logic                      accu_trig_o
);

  logic [esc_pkg::CNT_W-1:0] cnt_q;
  // count after this strobe, stuck at all ones
  logic [esc_pkg::CNT_W-1:0] cnt_inc;

  assign cnt_inc = (&cnt_q) ? cnt_q : cnt_q + 1'b1;

  //////////////////////////////
  // counter
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (accept_i) begin
      cnt_q <= cnt_inc;
    end
  end

  //////////////////////////////
  // threshold trigger
  //////////////////////////////

  // combinational, high in the strobe cycle itself
  // a clear in the same cycle wins, the count does not move then
  assign accu_trig_o = accept_i & ~clr_i & (cnt_inc >= thresh_i);

  assign cnt_o = cnt_q;

endmodule

//--- logic/esc_timer.sv
// escalation timer
// FSM Idle -> (Timeout) -> Phase0..Phase3 -> Terminal with one shared
// cycle counter for the interrupt timeout and the phase durations,
// maps phases onto escalation outputs and latches the crashdump

module esc_timer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  esc_pkg::esc_cfg_t             cfg_i,
  input  logic                          clr_i,
  input  logic                          timeout_en_i,
  input  logic                          accu_trig_i,
  input  logic [esc_pkg::CNT_W-1:0]     accu_cnt_i,
  output logic [esc_pkg::N_ESC_SEV-1:0] esc_sig_req_o,
  output esc_pkg::esc_status_t          status_o,
  output logic [esc_pkg::CNT_W-1:0]     crashdump_o
);

  esc_pkg::esc_state_e state_d, state_q;
  esc_pkg::esc_state_e dump_state;
  logic [esc_pkg::CNT_W-1:0]    cnt_q;
  logic                         cnt_clr;
  logic                         cnt_en;
  logic                         esc_trig;
  logic                         in_phase;
  logic [esc_pkg::PHASE_DW-1:0] phase_idx;
  // one extra bit so the compare never wraps
  logic [esc_pkg::CNT_W:0]      cnt_nxt;
  logic                         phase_done;
  logic                         latch_crashdump;
  logic                         crashdump_valid_q;
  logic [esc_pkg::CNT_W-1:0]    crashdump_q;

  // phase states have the msb set and the index below it
  assign in_phase  = state_q[2];
  assign phase_idx = state_q[1:0];

  // phase k lasts max(phase_cyc[k], 1) cycles, a zero setting gives one
  assign cnt_nxt    = {1'b0, cnt_q} + 1'b1;
  assign phase_done = cnt_nxt >= {1'b0, cfg_i.phase_cyc[phase_idx]};

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d  = state_q;
    esc_trig = 1'b0;
    cnt_clr  = 1'b0;
    cnt_en   = 1'b0;
    unique case (state_q)
      esc_pkg::Idle: begin
        cnt_clr = 1'b1;
        if (cfg_i.en && accu_trig_i) begin
          esc_trig = 1'b1;
          state_d  = esc_pkg::Phase0;
        end else if (cfg_i.en && timeout_en_i && cfg_i.timeout_cyc != '0) begin
          state_d = esc_pkg::Timeout;
        end
      end
      esc_pkg::Timeout: begin
        // clr only gets here through the irq level dropping
        if (accu_trig_i || cnt_q >= cfg_i.timeout_cyc) begin
          esc_trig = 1'b1;
          cnt_clr  = 1'b1;
          state_d  = esc_pkg::Phase0;
        end else if (!timeout_en_i) begin
          cnt_clr = 1'b1;
          state_d = esc_pkg::Idle;
        end else begin
          cnt_en = 1'b1;
        end
      end
      esc_pkg::Phase0, esc_pkg::Phase1, esc_pkg::Phase2, esc_pkg::Phase3: begin
        if (clr_i) begin
          cnt_clr = 1'b1;
          state_d = esc_pkg::Idle;
        end else if (phase_done) begin
          // counter restarts on every phase entry
          cnt_clr = 1'b1;
          if (phase_idx == esc_pkg::PHASE_DW'(esc_pkg::N_PHASES - 1)) begin
            state_d = esc_pkg::Terminal;
          end else begin
            state_d = esc_pkg::esc_state_e'({1'b1, phase_idx + 2'd1});
          end
        end else begin
          cnt_en = 1'b1;
        end
      end
      esc_pkg::Terminal: begin
        // held until cleared
        if (clr_i) begin
          cnt_clr = 1'b1;
          state_d = esc_pkg::Idle;
        end
      end
      default: begin
        cnt_clr = 1'b1;
        state_d = esc_pkg::Idle;
      end
    endcase
  end

  //////////////////////////////
  // crashdump
  //////////////////////////////

  // capture on the edge into the selected phase
  assign dump_state      = esc_pkg::esc_state_e'({1'b1, cfg_i.crashdump_phase});
  assign latch_crashdump = (state_d == dump_state) && (state_d != state_q);

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= esc_pkg::Idle;
      cnt_q             <= '0;
      crashdump_valid_q <= 1'b0;
      crashdump_q       <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_nxt[esc_pkg::CNT_W-1:0];
      end
      if (latch_crashdump) begin
        crashdump_valid_q <= 1'b1;
        crashdump_q       <= accu_cnt_i;
      end else if (clr_i) begin
        crashdump_valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // straight from the state register, no input path
  always_comb begin
    for (int i = 0; i < esc_pkg::N_ESC_SEV; i++) begin
      esc_sig_req_o[i] = cfg_i.esc_en[i] & in_phase & (cfg_i.esc_map[i] == phase_idx);
    end
  end

  assign status_o = '{
    state:           state_q,
    esc_cnt:         cnt_q,
    esc_trig:        esc_trig,
    crashdump_valid: crashdump_valid_q
  };

  assign crashdump_o = crashdump_q;

endmodule

//--- logic/esc_top.sv
// escalation class top
// alert intake feeds the accumulator with accept strobes and the timer
// with the irq level; the timer drives escalation and status

module esc_top #(
  parameter int unsigned N_ALERTS = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [N_ALERTS-1:0]           alert_i,
  input  logic [N_ALERTS-1:0]           alert_en_i,
  input  esc_pkg::esc_cfg_t             cfg_i,
  input  logic                          clr_i,
  output logic                          irq_o,
  output logic [esc_pkg::N_ESC_SEV-1:0] esc_sig_req_o,
  output esc_pkg::esc_status_t          status_o,
  output logic [esc_pkg::CNT_W-1:0]     crashdump_o
);

  // intake -> accumulator strobe
  logic                      accept;
  // accumulator -> timer
  logic                      accu_trig;
  logic [esc_pkg::CNT_W-1:0] accu_cnt;

  alert_intake #(
    .N_ALERTS (N_ALERTS)
  ) u_intake (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .alert_i    (alert_i),
    .alert_en_i (alert_en_i),
    .clr_i      (clr_i),
    .accept_o   (accept),
    .irq_o      (irq_o)
  );

  alert_accu u_accu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .clr_i       (clr_i),
    .thresh_i    (cfg_i.accu_thresh),
    .cnt_o       (accu_cnt),
    .accu_trig_o (accu_trig)
  );

  // irq level doubles as the timeout enable
  esc_timer u_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg_i),
    .clr_i         (clr_i),
    .timeout_en_i  (irq_o),
    .accu_trig_i   (accu_trig),
    .accu_cnt_i    (accu_cnt),
    .esc_sig_req_o (esc_sig_req_o),
    .status_o      (status_o),
    .crashdump_o   (crashdump_o)
  );

endmodule

//--- testbench/esc_timer_assertions.sv
// escalation timer assertions
// FSM properties of the escalation timer, bound into every esc_timer

module esc_timer_assertions (
  input logic                          clk_i,
  input logic                          rst_ni,
  input esc_pkg::esc_cfg_t             cfg_i,
  input logic                          clr_i,
  input esc_pkg::esc_state_e           state_i,
  input logic                          esc_trig_i,
  input logic [esc_pkg::N_ESC_SEV-1:0] esc_sig_req_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far, polled by the testbench every cycle
  int unsigned fail_cnt = 0;
  logic        in_phase;

  assign in_phase = state_i inside {esc_pkg::Phase0, esc_pkg::Phase1,
                                    esc_pkg::Phase2, esc_pkg::Phase3};

  //////////////////////////////
  // properties
  //////////////////////////////

  // a disabled class never escalates out of Idle
  no_trig_disabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == esc_pkg::Idle && !cfg_i.en) |-> !esc_trig_i)
    else begin
      $error("esc_trig raised in Idle with the class disabled");
      fail_cnt++;
    end

  // escalation outputs only while a phase is active
  sig_only_in_phase: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|esc_sig_req_i) |-> in_phase)
    else begin
      $error("escalation output high outside of a phase state");
      fail_cnt++;
    end

  // Terminal is sticky until a clear
  terminal_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == esc_pkg::Terminal && !clr_i) |=> state_i == esc_pkg::Terminal)
    else begin
      $error("Terminal left without clr");
      fail_cnt++;
    end

  // clr in a phase goes straight back to Idle
  clr_leaves_phase: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_phase && clr_i) |=> state_i == esc_pkg::Idle)
    else begin
      $error("clr in a phase state did not return to Idle");
      fail_cnt++;
    end

endmodule

bind esc_timer esc_timer_assertions u_timer_asrt (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .cfg_i         (cfg_i),
  .clr_i         (clr_i),
  .state_i       (state_q),
  .esc_trig_i    (esc_trig),
  .esc_sig_req_i (esc_sig_req_o)
);

//--- testbench/tb_esc.sv
// escalation class testbench
// random alerts, clears and configurations against a cycle level
// reference model of intake, accumulator and escalation timer

module tb_esc;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ALERTS = 4;
  localparam int N_SEG    = 40;
  localparam int SEG_CYC  = 80;
  localparam int CLR_CYC  = 2;
  localparam int RST_CYC  = 16;
  // whole run in ns plus some slack
  localparam int WD_NS    = (RST_CYC + N_SEG * (SEG_CYC + CLR_CYC + 1) + 100) * 10;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic [N_ALERTS-1:0]           alert_i;
  logic [N_ALERTS-1:0]           alert_en_i;
  esc_pkg::esc_cfg_t             cfg_i;
  logic                          clr_i;
  logic                          irq_o;
  logic [esc_pkg::N_ESC_SEV-1:0] esc_sig_req_o;
  esc_pkg::esc_status_t          status_o;
  logic [15:0]                   crashdump_o;

  integer seed;
  int     dens;

  // model registers and their next values
  logic m_irq, m_accept, m_dump_valid, n_irq, n_accept, n_dump_valid;
  logic [15:0] m_cnt, m_tcnt, m_dump, n_cnt, n_tcnt, n_dump;
  esc_pkg::esc_state_e m_state, n_state;
  // combinational expectations of the current cycle
  logic exp_trig;
  logic [esc_pkg::N_ESC_SEV-1:0] exp_sig;

  esc_top #(.N_ALERTS(N_ALERTS)) dut0 (.*);

  always #5 clk_i = ~clk_i;

  function automatic int rand_upto(int hi);
    return ($random(seed) & 32'h7fff_ffff) % (hi + 1);
  endfunction

  function automatic esc_pkg::esc_state_e phase_state(int k);
    case (k)
      0:       return esc_pkg::Phase0;
      1:       return esc_pkg::Phase1;
      2:       return esc_pkg::Phase2;
      default: return esc_pkg::Phase3;
    endcase
  endfunction

  // phase index of a state or -1 outside the phases
  function automatic int phase_of(esc_pkg::esc_state_e s);
    case (s)
      esc_pkg::Phase0: return 0;
      esc_pkg::Phase1: return 1;
      esc_pkg::Phase2: return 2;
      esc_pkg::Phase3: return 3;
      default:         return -1;
    endcase
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  task automatic model_eval();
    logic        evt;
    logic        accu_trig;
    logic [15:0] cnt_after;
    int          k;
    int          len;
    evt       = |(alert_i & alert_en_i);
    n_accept  = evt && !clr_i;
    n_irq     = clr_i ? 1'b0 : (evt ? 1'b1 : m_irq);
    cnt_after = (m_cnt == 16'hffff) ? m_cnt : m_cnt + 16'd1;
    accu_trig = m_accept && !clr_i && (cnt_after >= cfg_i.accu_thresh);
    n_cnt     = clr_i ? 16'd0 : (m_accept ? cnt_after : m_cnt);
    exp_trig  = 1'b0;
    n_state   = m_state;
    n_tcnt    = m_tcnt;
    k         = phase_of(m_state);
    if (m_state == esc_pkg::Idle) begin
      n_tcnt = 16'd0;
      if (cfg_i.en && accu_trig) begin
        exp_trig = 1'b1;
        n_state  = esc_pkg::Phase0;
      end else if (cfg_i.en && m_irq && cfg_i.timeout_cyc != 16'd0) begin
        n_state = esc_pkg::Timeout;
      end
    end else if (m_state == esc_pkg::Timeout) begin
      // clr reaches Timeout only through irq
      if (accu_trig || m_tcnt >= cfg_i.timeout_cyc) begin
        exp_trig = 1'b1;
        n_state  = esc_pkg::Phase0;
        n_tcnt   = 16'd0;
      end else if (!m_irq) begin
        n_state = esc_pkg::Idle;
        n_tcnt  = 16'd0;
      end else begin
        n_tcnt = m_tcnt + 16'd1;
      end
    end else if (m_state == esc_pkg::Terminal) begin
      if (clr_i) begin
        n_state = esc_pkg::Idle;
        n_tcnt  = 16'd0;
      end
    end else begin
      len = (cfg_i.phase_cyc[k] == 16'd0) ? 1 : int'(cfg_i.phase_cyc[k]);
      if (clr_i) begin
        n_state = esc_pkg::Idle;
        n_tcnt  = 16'd0;
      end else if (int'(m_tcnt) + 1 >= len) begin
        n_tcnt  = 16'd0;
        n_state = (k == 3) ? esc_pkg::Terminal : phase_state(k + 1);
      end else begin
        n_tcnt = m_tcnt + 16'd1;
      end
    end
    for (int i = 0; i < esc_pkg::N_ESC_SEV; i++) begin
      exp_sig[i] = cfg_i.esc_en[i] && (k == int'(cfg_i.esc_map[i]));
    end
    // capture on entry to the chosen phase wins over clr
    if (n_state != m_state && n_state == phase_state(cfg_i.crashdump_phase)) begin
      n_dump_valid = 1'b1;
      n_dump       = m_cnt;
    end else begin
      n_dump_valid = clr_i ? 1'b0 : m_dump_valid;
      n_dump       = m_dump;
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    $display("*** FAILED ***");
    $fatal(1, "DUT output differs from the reference model");
  endtask

  task automatic check_outputs();
    assert (irq_o === m_irq) else report_mismatch("irq_o", irq_o, m_irq);
    assert (esc_sig_req_o === exp_sig)
      else report_mismatch("esc_sig_req_o", esc_sig_req_o, exp_sig);
    assert (status_o.state === m_state)
      else report_mismatch("state", status_o.state, m_state);
    assert (status_o.esc_cnt === m_tcnt)
      else report_mismatch("esc_cnt", status_o.esc_cnt, m_tcnt);
    assert (status_o.esc_trig === exp_trig)
      else report_mismatch("esc_trig", status_o.esc_trig, exp_trig);
    assert (status_o.crashdump_valid === m_dump_valid)
      else report_mismatch("crashdump_valid", status_o.crashdump_valid, m_dump_valid);
    assert (crashdump_o === m_dump) else report_mismatch("crashdump_o", crashdump_o, m_dump);
  endtask

  // the bound FSM checker counts its own failures
  task automatic check_fsm_assertions();
    assert (dut0.u_timer.u_timer_asrt.fail_cnt == 0) else begin
      $display("an escalation timer assertion failed before %0t ns", $time);
      $display("*** FAILED ***");
      $fatal(1, "escalation timer assertion failure");
    end
  endtask

  // inputs are stable at the falling edge and are what the next rising edge sees
  always @(negedge clk_i) begin
    if (rst_ni) begin
      model_eval();
      check_outputs();
      check_fsm_assertions();
      {m_irq, m_accept, m_dump_valid} = {n_irq, n_accept, n_dump_valid};
      {m_cnt, m_tcnt, m_dump}         = {n_cnt, n_tcnt, n_dump};
      m_state                         = n_state;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // small counts so that whole escalations fit into a segment
  task automatic new_config();
    cfg_i.en              <= (rand_upto(7) != 0);
    cfg_i.accu_thresh     <= 16'(rand_upto(8));
    cfg_i.timeout_cyc     <= 16'(rand_upto(8));
    cfg_i.esc_en          <= 4'($random(seed));
    cfg_i.esc_map         <= 8'($random(seed));
    cfg_i.crashdump_phase <= 2'(rand_upto(3));
    for (int j = 0; j < esc_pkg::N_PHASES; j++) begin
      cfg_i.phase_cyc[j] <= 16'(rand_upto(8));
    end
    alert_en_i <= N_ALERTS'($random(seed));
    dens       = rand_upto(3);
  endtask

  initial begin
    seed         = 32'h7f327eaa;
    rst_ni       = 1'b0;
    alert_i      = '0;
    alert_en_i   = '0;
    cfg_i        = '0;
    clr_i        = 1'b0;
    {m_irq, m_accept, m_dump_valid} = 3'b000;
    {m_cnt, m_tcnt, m_dump}         = '0;
    m_state      = esc_pkg::Idle;
    repeat (RST_CYC) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int seg = 0; seg < N_SEG; seg++) begin
      // clear back to Idle before the next configuration
      repeat (CLR_CYC) begin
        @(posedge clk_i);
        clr_i   <= 1'b1;
        alert_i <= '0;
      end
      @(posedge clk_i);
      clr_i <= 1'b0;
      new_config();
      repeat (SEG_CYC) begin
        @(posedge clk_i);
        alert_i <= (rand_upto(3) < dens) ? N_ALERTS'($random(seed)) : '0;
        clr_i   <= (rand_upto(47) == 0);
      end
    end
    @(posedge clk_i);
    alert_i <= '0;
    clr_i   <= 1'b0;
    @(negedge clk_i);
    @(negedge clk_i);
    // past the model check of the last falling edge
    #1;
    $display("*** PASSED ***");
    $finish;
  end

  // watchdog
  initial begin
    #(WD_NS);
    $display("watchdog expired before the stimulus finished");
    $display("*** FAILED ***");
    $fatal(1, "simulation timeout");
  end

endmodule

//--- list.f
logic/esc_pkg.sv
logic/alert_intake.sv
logic/alert_accu.sv
logic/esc_timer.sv
logic/esc_top.sv
testbench/esc_timer_assertions.sv
testbench/tb_esc.sv
